// File: hw/loop_pkg.sv
`default_nettype none

package loop_pkg;

  //////////////////////////////
  // widths and depths
  //////////////////////////////

  localparam int ADC_RAW_W = 16;  // raw converter word
  localparam int SAMPLE_W  = 14;  // signed loop sample
  localparam int KP_W      = 8;
  localparam int KP_SHIFT  = 4;   // gain scaling after multiply
  localparam int CAP_DEPTH = 16;
  localparam int CAP_AW    = 4;
  localparam int APB_AW    = 8;
  localparam int APB_DW    = 32;

  localparam logic [APB_AW-1:0] BUF_BASE = 8'h40;  // buffer word 0

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SAMPLE_W:0]   sum_t;       // one guard bit
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // neg slope, unsigned
  typedef logic signed [KP_W-1:0]     kp_t;

  localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
  localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});

  typedef enum logic [1:0] {
    CAP_IDLE = 2'd0,
    CAP_RUN  = 2'd1,
    CAP_DONE = 2'd2
  } cap_state_e;

  // register byte offsets
  typedef enum logic [APB_AW-1:0] {
    REG_CTRL     = 8'h00,  // [0] digital_loop, [1] arm
    REG_STATUS   = 8'h04,  // [0] done [1] busy [2] railed_lo [3] railed_hi
    REG_SETPOINT = 8'h08,
    REG_KP       = 8'h0C,
    REG_OFFSET   = 8'h10,
    REG_LIM_LO   = 8'h14,
    REG_LIM_HI   = 8'h18
  } reg_addr_e;

  // clip a sign extended value into sample range
  function automatic sample_t sat_sample(input logic signed [31:0] v);
    if (v > 32'(SAMPLE_MAX))
      return SAMPLE_MAX;
    else if (v < 32'(SAMPLE_MIN))
      return SAMPLE_MIN;
    return sample_t'(v[SAMPLE_W-1:0]);
  endfunction

endpackage

`default_nettype wire

// File: hw/adc_frontend.sv
`default_nettype none

module adc_frontend (
  input  wire logic                           adc_clk,
  input  wire logic                           reset_i,
  input  wire logic [loop_pkg::ADC_RAW_W-1:0] adc_dat_i,       // raw converter word
  input  wire logic                           digital_loop_i,  // take limited instead
  input  wire loop_pkg::sample_t              limited_i,
  output loop_pkg::sample_t                   sample_o
);

  import loop_pkg::*;

  logic [SAMPLE_W-1:0] adc_raw;  // top bits of the input word

  //////////////////////////////
  // input register
  //////////////////////////////

  // low two bits dropped, 14 bit sample
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      adc_raw <= {1'b0, {(SAMPLE_W-1){1'b1}}};  // converts to zero
    else
      adc_raw <= adc_dat_i[ADC_RAW_W-1:ADC_RAW_W-SAMPLE_W];
  end

  // negative slope offset binary to two's complement
  // sign bit kept, rest inverted
  assign sample_o = digital_loop_i ? limited_i
                                   : sample_t'({adc_raw[SAMPLE_W-1], ~adc_raw[SAMPLE_W-2:0]});

endmodule

`default_nettype wire

// File: hw/p_controller.sv
`default_nettype none

module p_controller (
  input  wire logic              adc_clk,
  input  wire logic              reset_i,
  input  wire loop_pkg::sample_t sample_i,    // measured value
  input  wire loop_pkg::sample_t setpoint_i,
  input  wire loop_pkg::kp_t     kp_i,        // proportional gain
  output loop_pkg::sample_t      ctrl_o
);

  import loop_pkg::*;

  typedef logic signed [SAMPLE_W+KP_W:0] prod_t;  // 15 x 8 bit product

  sum_t    err;      // setpoint - sample, no overflow
  prod_t   prod;
  prod_t   scaled;   // after gain shift
  sample_t ctrl_nx;

  //////////////////////////////
  // error and gain
  //////////////////////////////

  assign err    = sum_t'(setpoint_i) - sum_t'(sample_i);
  assign prod   = prod_t'(err) * prod_t'(kp_i);  // signed multiply
  assign scaled = prod >>> KP_SHIFT;             // arithmetic, keeps sign

  // clip to 14 bits at both ends
  assign ctrl_nx = sat_sample(32'(scaled));

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ctrl_o <= '0;
    else
      ctrl_o <= ctrl_nx;
  end

endmodule

`default_nettype wire

// File: hw/dac_output.sv
`default_nettype none

module dac_output (
  input  wire logic              adc_clk,
  input  wire logic              reset_i,
  input  wire loop_pkg::sample_t ctrl_i,       // controller output
  input  wire loop_pkg::sample_t offset_i,     // dc offset
  input  wire loop_pkg::sample_t lim_lo_i,
  input  wire loop_pkg::sample_t lim_hi_i,
  output loop_pkg::sample_t      limited_o,    // also fed back for loopback
  output logic                   railed_lo_o,
  output logic                   railed_hi_o,
  output loop_pkg::dac_code_t    dac_dat_o
);

  import loop_pkg::*;

  sum_t    sum;       // controller + offset, 15 bit
  sample_t sat;       // sum clipped to sample range
  sample_t clamped;   // sat inside programmable window
  logic    below_lo;
  logic    above_hi;

  //////////////////////////////
  // sum, saturation, clamp
  //////////////////////////////

  assign sum = sum_t'(ctrl_i) + sum_t'(offset_i);
  assign sat = sat_sample(32'(sum));

  assign below_lo = sat < lim_lo_i;
  assign above_hi = sat > lim_hi_i;

  // low limit wins if the window is inverted
  always_comb
  begin
    clamped = sat;
    if (above_hi)
      clamped = lim_hi_i;
    if (below_lo)
      clamped = lim_lo_i;
  end

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      limited_o   <= '0;
      railed_lo_o <= 1'b0;
      railed_hi_o <= 1'b0;
      dac_dat_o   <= dac_code_t'({1'b0, {(SAMPLE_W-1){1'b1}}});  // code of zero
    end
    else
    begin
      limited_o   <= clamped;
      railed_lo_o <= below_lo;
      railed_hi_o <= above_hi;
      // signed to negative slope code, one stage later
      dac_dat_o   <= dac_code_t'({limited_o[SAMPLE_W-1], ~limited_o[SAMPLE_W-2:0]});
    end
  end

endmodule

`default_nettype wire

// File: hw/capture_ctrl.sv
`default_nettype none

module capture_ctrl (
  input  wire logic                        adc_clk,
  input  wire logic                        reset_i,
  input  wire logic                        arm_i,      // one cycle pulse
  input  wire loop_pkg::sample_t           sample_i,
  output logic                             wr_en_o,
  output logic [loop_pkg::CAP_AW-1:0]      wr_addr_o,
  output loop_pkg::sample_t                wr_data_o,
  output logic                             busy_o,
  output logic                             done_o
);

  import loop_pkg::*;

  cap_state_e        state;
  logic [CAP_AW-1:0] addr;   // next buffer word

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      state <= CAP_IDLE;
      addr  <= '0;
    end
    else if (arm_i)
    begin
      state <= CAP_RUN;  // also restarts a running capture
      addr  <= '0;
    end
    else
    begin
      case (state)
        CAP_RUN:
        begin
          addr <= addr + 1'b1;
          if (addr == CAP_AW'(CAP_DEPTH-1))
            state <= CAP_DONE;  // last word this cycle
        end
        default: ;  // idle and done wait for arm
      endcase
    end
  end

  assign busy_o    = (state == CAP_RUN);
  assign done_o    = (state == CAP_DONE);
  assign wr_en_o   = busy_o;      // one word per cycle
  assign wr_addr_o = addr;
  assign wr_data_o = sample_i;

endmodule

`default_nettype wire

// File: hw/sample_buffer.sv
`default_nettype none

module sample_buffer (
  input  wire logic                        adc_clk,
  input  wire logic                        reset_i,
  // capture port, always wins
  input  wire logic                        wr_en_i,
  input  wire logic [loop_pkg::CAP_AW-1:0] wr_addr_i,
  input  wire loop_pkg::sample_t           wr_data_i,
  // bus read port
  input  wire logic                        rd_req_i,   // held until rd_valid_o
  input  wire logic [loop_pkg::CAP_AW-1:0] rd_addr_i,
  output logic                             rd_valid_o,
  output loop_pkg::sample_t                rd_data_o
);

  import loop_pkg::*;

  sample_t mem [CAP_DEPTH];  // single port storage
  logic    rd_gnt;

  //////////////////////////////
  // arbiter
  //////////////////////////////

  // read only in a free cycle, and not again while valid is up
  assign rd_gnt = rd_req_i & ~wr_en_i & ~rd_valid_o;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      rd_valid_o <= 1'b0;
    else
      rd_valid_o <= rd_gnt;  // one cycle after grant
  end

  //////////////////////////////
  // memory
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
    else if (rd_gnt)
      rd_data_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

// File: hw/apb_regs.sv
`default_nettype none

module apb_regs (
  input  wire logic                        adc_clk,
  input  wire logic                        reset_i,
  // apb slave
  input  wire logic                        psel_i,
  input  wire logic                        penable_i,
  input  wire logic                        pwrite_i,
  input  wire logic [loop_pkg::APB_AW-1:0] paddr_i,
  input  wire logic [loop_pkg::APB_DW-1:0] pwdata_i,
  output logic      [loop_pkg::APB_DW-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  // status
  input  wire logic                        busy_i,
  input  wire logic                        done_i,
  input  wire logic                        railed_lo_i,
  input  wire logic                        railed_hi_i,
  // buffer read port
  input  wire logic                        rd_valid_i,
  input  wire loop_pkg::sample_t           rd_data_i,
  output logic                             rd_req_o,
  output logic      [loop_pkg::CAP_AW-1:0] rd_addr_o,
  // configuration
  output logic                             digital_loop_o,
  output logic                             arm_o,        // single cycle
  output loop_pkg::sample_t                setpoint_o,
  output loop_pkg::sample_t                offset_o,
  output loop_pkg::sample_t                lim_lo_o,
  output loop_pkg::sample_t                lim_hi_o,
  output loop_pkg::kp_t                    kp_o
);

  import loop_pkg::*;

  logic access;    // second apb phase
  logic reg_hit;
  logic buf_hit;   // aligned word in the buffer window
  logic err;       // unmapped or not writable
  logic wr_ok;
  logic buf_rd;

  //////////////////////////////
  // address decode
  //////////////////////////////

  assign access = psel_i & penable_i;

  always_comb
  begin
    case (paddr_i)
      REG_CTRL, REG_STATUS, REG_SETPOINT, REG_KP,
      REG_OFFSET, REG_LIM_LO, REG_LIM_HI: reg_hit = 1'b1;
      default:                            reg_hit = 1'b0;
    endcase
  end

  // 0x40..0x7c, 16 words
  assign buf_hit = (paddr_i[APB_AW-1:CAP_AW+2] == BUF_BASE[APB_AW-1:CAP_AW+2])
                 & (paddr_i[1:0] == 2'b00);

  assign err    = ~(reg_hit | buf_hit)
                | (pwrite_i & (buf_hit | (paddr_i == REG_STATUS)));
  assign wr_ok  = access & pwrite_i & ~err;
  assign buf_rd = access & buf_hit & ~pwrite_i;

  // buffer side handshake
  assign rd_req_o  = buf_rd;
  assign rd_addr_o = paddr_i[CAP_AW+1:2];

  assign pready_o  = ~buf_rd | rd_valid_i;  // stall only on buffer reads
  assign pslverr_o = access & err;

  //////////////////////////////
  // register writes
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      digital_loop_o <= 1'b0;
      arm_o          <= 1'b0;
      setpoint_o     <= '0;
      kp_o           <= '0;
      offset_o       <= '0;
      lim_lo_o       <= SAMPLE_MIN;  // full range open
      lim_hi_o       <= SAMPLE_MAX;
    end
    else
    begin
      arm_o <= 1'b0;  // pulse
      if (wr_ok)
      begin
        case (paddr_i)
          REG_CTRL:
          begin
            digital_loop_o <= pwdata_i[0];
            arm_o          <= pwdata_i[1];
          end
          REG_SETPOINT: setpoint_o <= sample_t'(pwdata_i[SAMPLE_W-1:0]);
          REG_KP:       kp_o       <= kp_t'(pwdata_i[KP_W-1:0]);
          REG_OFFSET:   offset_o   <= sample_t'(pwdata_i[SAMPLE_W-1:0]);
          REG_LIM_LO:   lim_lo_o   <= sample_t'(pwdata_i[SAMPLE_W-1:0]);
          REG_LIM_HI:   lim_hi_o   <= sample_t'(pwdata_i[SAMPLE_W-1:0]);
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  // signed fields come back sign extended
  always_comb
  begin
    prdata_o = '0;
    if (buf_rd)
      prdata_o = rd_valid_i ? APB_DW'(rd_data_i) : '0;
    else if (!err)
    begin
      case (paddr_i)
        REG_CTRL:     prdata_o = APB_DW'(digital_loop_o);  // arm reads 0
        REG_STATUS:   prdata_o = APB_DW'({railed_hi_i, railed_lo_i, busy_i, done_i});
        REG_SETPOINT: prdata_o = APB_DW'(setpoint_o);
        REG_KP:       prdata_o = APB_DW'(kp_o);
        REG_OFFSET:   prdata_o = APB_DW'(offset_o);
        REG_LIM_LO:   prdata_o = APB_DW'(lim_lo_o);
        REG_LIM_HI:   prdata_o = APB_DW'(lim_hi_o);
        default:      prdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/loop_ctrl_top.sv
`default_nettype none

module loop_ctrl_top (
  input  wire logic                           adc_clk,
  input  wire logic                           reset_i,
  // adc
  input  wire logic [loop_pkg::ADC_RAW_W-1:0] adc_dat_i,
  // apb slave
  input  wire logic                           psel_i,
  input  wire logic                           penable_i,
  input  wire logic                           pwrite_i,
  input  wire logic [loop_pkg::APB_AW-1:0]    paddr_i,
  input  wire logic [loop_pkg::APB_DW-1:0]    pwdata_i,
  output logic      [loop_pkg::APB_DW-1:0]    prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  // dac
  output loop_pkg::dac_code_t                 dac_dat_o
);

  import loop_pkg::*;

  sample_t           sample;                 // front end -> controller, scope
  sample_t           ctrl_out;
  sample_t           limited;                // fed back for loopback
  logic              railed_lo, railed_hi;
  logic              digital_loop, arm;
  sample_t           setpoint, offset, lim_lo, lim_hi;
  kp_t               kp;
  logic              busy, done;
  logic              wr_en;
  logic [CAP_AW-1:0] wr_addr;
  sample_t           wr_data;
  logic              rd_req, rd_valid;
  logic [CAP_AW-1:0] rd_addr;
  sample_t           rd_data;

  //////////////////////////////
  // loop datapath
  //////////////////////////////

  adc_frontend i_adc (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_dat_i      (adc_dat_i),
    .digital_loop_i (digital_loop),
    .limited_i      (limited),
    .sample_o       (sample)
  );

  p_controller i_pctrl (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .sample_i   (sample),
    .setpoint_i (setpoint),
    .kp_i       (kp),
    .ctrl_o     (ctrl_out)
  );

  dac_output i_dac (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .ctrl_i      (ctrl_out),
    .offset_i    (offset),
    .lim_lo_i    (lim_lo),
    .lim_hi_i    (lim_hi),
    .limited_o   (limited),
    .railed_lo_o (railed_lo),
    .railed_hi_o (railed_hi),
    .dac_dat_o   (dac_dat_o)
  );

  //////////////////////////////
  // scope and bus
  //////////////////////////////

  capture_ctrl i_cap (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .arm_i (arm), .sample_i (sample),
    .wr_en_o (wr_en), .wr_addr_o (wr_addr), .wr_data_o (wr_data),
    .busy_o (busy), .done_o (done)
  );

  sample_buffer i_buf (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
    .rd_req_i (rd_req), .rd_addr_i (rd_addr),
    .rd_valid_o (rd_valid), .rd_data_o (rd_data)
  );

  apb_regs i_regs (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
    .pready_o (pready_o), .pslverr_o (pslverr_o),
    .busy_i (busy), .done_i (done),
    .railed_lo_i (railed_lo), .railed_hi_i (railed_hi),
    .rd_valid_i (rd_valid), .rd_data_i (rd_data),
    .rd_req_o (rd_req), .rd_addr_o (rd_addr),
    .digital_loop_o (digital_loop), .arm_o (arm),
    .setpoint_o (setpoint), .offset_o (offset),
    .lim_lo_o (lim_lo), .lim_hi_o (lim_hi), .kp_o (kp)
  );

endmodule

`default_nettype wire

// File: sim/tb_props.sv
`default_nettype none

module tb_props (
  input wire logic                        adc_clk,
  input wire logic                        reset_i,
  input wire logic                        psel_i,
  input wire logic                        penable_i,
  input wire logic                        pwrite_i,
  input wire logic [loop_pkg::APB_AW-1:0] paddr_i,
  input wire logic                        pready_o,
  input wire logic                        pslverr_o,
  input wire logic                        busy_i,
  input wire logic                        rd_req_o,
  input wire logic [loop_pkg::CAP_AW-1:0] rd_addr_o,
  input wire logic                        rd_valid_i
);

  import loop_pkg::*;

  logic buf_access;  // read access phase in the buffer window

  assign buf_access = psel_i & penable_i & ~pwrite_i
                    & (paddr_i[APB_AW-1:CAP_AW+2] == BUF_BASE[APB_AW-1:CAP_AW+2])
                    & (paddr_i[1:0] == 2'b00);

  // error only on a completing transfer
  a_err_ready: assert property (@(posedge adc_clk) disable iff (reset_i)
    pslverr_o |-> pready_o)
    else $error("pslverr without pready");

  // capture keeps a stalled buffer read waiting
  a_stall: assert property (@(posedge adc_clk) disable iff (reset_i)
    (buf_access && !pready_o && busy_i) |=> !pready_o)
    else $error("buffer read served while capture was running");

  // request held until served
  a_req_hold: assert property (@(posedge adc_clk) disable iff (reset_i)
    (rd_req_o && !rd_valid_i) |=> (rd_req_o && $stable(rd_addr_o)))
    else $error("rd_req dropped before rd_valid");

endmodule

bind apb_regs tb_props u_props (
  .adc_clk (adc_clk), .reset_i (reset_i),
  .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
  .paddr_i (paddr_i), .pready_o (pready_o), .pslverr_o (pslverr_o),
  .busy_i (busy_i),
  .rd_req_o (rd_req_o), .rd_addr_o (rd_addr_o), .rd_valid_i (rd_valid_i)
);

`default_nettype wire

// File: sim/tb_top.sv
`default_nettype none

module tb_top;

  import loop_pkg::*;

  localparam int N_FIXED     = 7;
  localparam int N_RAND      = 8;
  localparam int N_ROWS      = N_FIXED + N_RAND;
  localparam int CYCLE_LIMIT = N_ROWS * 40 + 400;  // rows plus capture tests

  logic                 adc_clk;
  logic                 reset_i;
  logic [ADC_RAW_W-1:0] adc_dat_i;
  logic                 psel_i, penable_i, pwrite_i;
  logic [APB_AW-1:0]    paddr_i;
  logic [APB_DW-1:0]    pwdata_i;
  logic [APB_DW-1:0]    prdata_o;
  logic                 pready_o, pslverr_o;
  dac_code_t            dac_dat_o;

  // stimulus table with one entry per row
  int t_raw [N_ROWS];
  int t_loop [N_ROWS];
  int t_sp [N_ROWS];
  int t_kp [N_ROWS];
  int t_off [N_ROWS];
  int t_lo [N_ROWS];
  int t_hi [N_ROWS];
  int t_code [N_ROWS];    // expected dac code
  int t_railed [N_ROWS];  // {hi, lo}

  logic [31:0] lfsr;
  int          cycles;

  loop_ctrl_top uut (.*);

  //////////////////////////////
  // clock, timeout
  //////////////////////////////

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic int sext14(input int v);
    return ((v & 'h3FFF) ^ 'h2000) - 'h2000;
  endfunction

  function automatic int clip14(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  // drop two lsbs and flip the magnitude bits of the offset binary word
  function automatic int raw_to_sample(input int raw);
    return sext14(((raw >> 2) & 'h3FFF) ^ 'h1FFF);
  endfunction

  function automatic int sample_to_code(input int v);
    return (v & 'h3FFF) ^ 'h1FFF;
  endfunction

  task automatic predict_row(input int i);
    int smp;
    int ctrl;
    int sum;
    int lim;
    smp  = t_loop[i] ? 0 : raw_to_sample(t_raw[i]);  // loop rows run with kp 0
    ctrl = clip14(((t_sp[i] - smp) * t_kp[i]) >>> 4);
    sum  = clip14(ctrl + t_off[i]);
    lim  = sum;
    if (sum > t_hi[i])
      lim = t_hi[i];
    if (sum < t_lo[i])
      lim = t_lo[i];
    t_railed[i] = ((sum > t_hi[i]) ? 2 : 0) | ((sum < t_lo[i]) ? 1 : 0);
    t_code[i]   = sample_to_code(lim);
  endtask

  //////////////////////////////
  // random source
  //////////////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    repeat (n)
    begin
      v    = (v << 1) | int'(lfsr[0]);  // one step per bit
      lfsr = galois_step(lfsr);
    end
  endtask

  //////////////////////////////
  // apb transfers
  //////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge adc_clk);
    psel_i    = 1'b1;  // setup
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge adc_clk);
    penable_i = 1'b1;
    @(posedge adc_clk);
    while (!pready_o)
      @(posedge adc_clk);
    err = pslverr_o;
    @(negedge adc_clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err, output int waits);
    waits = 0;
    @(negedge adc_clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge adc_clk);
    penable_i = 1'b1;
    @(posedge adc_clk);
    while (!pready_o)  // buffer reads stall here
    begin
      waits++;
      @(posedge adc_clk);
    end
    data = prdata_o;
    err  = pslverr_o;
    @(negedge adc_clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic write_cfg(input int loop, input int sp, input int kp, input int off,
                           input int lo, input int hi);
    logic err;
    apb_write(8'(REG_SETPOINT), 32'(sp), err);
    apb_write(8'(REG_KP), 32'(kp), err);
    apb_write(8'(REG_OFFSET), 32'(off), err);
    apb_write(8'(REG_LIM_LO), 32'(lo), err);
    apb_write(8'(REG_LIM_HI), 32'(hi), err);
    apb_write(8'(REG_CTRL), 32'(loop), err);
  endtask

  task automatic wait_done();
    logic [31:0] d;
    logic        err;
    int          w;
    d = '0;
    while (!d[0])  // poll until capture done
      apb_read(8'(REG_STATUS), d, err, w);
    check_word("status busy", (d >> 1) & 32'd1, 32'd0);
  endtask

  task automatic check_buffer(input int exp);
    logic [31:0] d;
    logic        err;
    int          w;
    for (int k = 0; k < CAP_DEPTH; k++)
    begin
      apb_read(8'(int'(BUF_BASE) + 4 * k), d, err, w);
      check_sample("buffer word", sample_t'(d[SAMPLE_W-1:0]), sample_t'(exp));
    end
  endtask

  task automatic set_row(input int i, input int raw, input int loop, input int sp,
                         input int kp, input int off, input int lo, input int hi,
                         input int code, input int railed);
    t_raw[i]    = raw;
    t_loop[i]   = loop;
    t_sp[i]     = sp;
    t_kp[i]     = kp;
    t_off[i]    = off;
    t_lo[i]     = lo;
    t_hi[i]     = hi;
    t_code[i]   = code;
    t_railed[i] = railed;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    logic [31:0] d;
    logic        err;
    int          w;
    int          r;
    cycles    = 0;
    lfsr      = 32'hd158_02cf;
    reset_i   = 1'b1;
    adc_dat_i = 16'h7FFF;  // mid scale
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    repeat (16) @(posedge adc_clk);
    @(negedge adc_clk);
    reset_i = 1'b0;

    // reset values
    check_code("dac_dat_o", dac_dat_o, 14'h1FFF);
    apb_read(8'(REG_CTRL), d, err, w);
    check_word("ctrl", d, 32'h0);
    apb_read(8'(REG_STATUS), d, err, w);
    check_word("status", d, 32'h0);
    apb_read(8'(REG_SETPOINT), d, err, w);
    check_word("setpoint", d, 32'h0);
    apb_read(8'(REG_KP), d, err, w);
    check_word("kp", d, 32'h0);
    apb_read(8'(REG_OFFSET), d, err, w);
    check_word("offset", d, 32'h0);
    apb_read(8'(REG_LIM_LO), d, err, w);
    check_word("lim_lo", d, 32'hFFFF_E000);
    apb_read(8'(REG_LIM_HI), d, err, w);
    check_word("lim_hi", d, 32'h0000_1FFF);
    apb_read(8'h20, d, err, w);            // hole in the map
    check_word("pslverr", 32'(err), 32'd1);
    check_word("unmapped data", d, 32'h0);

    // fixed rows with codes worked out by hand
    set_row(0, 'h7FFF, 0, 100, 16, 50, -8192, 8191, 'h1F69, 0);
    set_row(1, 'h7FFF, 0, 8191, 127, 0, -8192, 8191, 'h0000, 0);
    set_row(2, 'h7FFF, 0, -8192, 127, 0, -8192, 8191, 'h3FFF, 0);
    set_row(3, 'h7FFF, 0, 100, 16, 50, -100, 100, 'h1F9B, 2);
    set_row(4, 'h7FFF, 0, -100, 16, -50, -100, 100, 'h2063, 1);
    set_row(5, 'h831C, 0, 0, 8, 10, -8192, 8191, 'h1F91, 0);
    set_row(6, 'h7FFF, 1, 0, 0, 300, -8192, 8191, 'h1ED3, 0);
    for (int i = N_FIXED; i < N_ROWS; i++)
    begin
      take_bits(16, r);
      set_row(i, r, 0, 500, 24, -40, -3000, 3000, 0, 0);
      predict_row(i);  // fills in code and railed
    end

    for (int i = 0; i < N_ROWS; i++)
    begin
      @(negedge adc_clk);
      adc_dat_i = 16'(t_raw[i]);
      write_cfg(t_loop[i], t_sp[i], t_kp[i], t_off[i], t_lo[i], t_hi[i]);
      repeat (8) @(posedge adc_clk);  // pipeline settles
      @(negedge adc_clk);
      check_code("dac_dat_o", dac_dat_o, dac_code_t'(t_code[i]));
      apb_read(8'(REG_STATUS), d, err, w);
      check_word("status railed", (d >> 2) & 32'd3, 32'(t_railed[i]));
    end

    // loopback capture of the offset
    write_cfg(1, 0, 0, 300, -8192, 8191);
    repeat (8) @(posedge adc_clk);
    apb_write(8'(REG_CTRL), 32'd3, err);  // loop plus arm
    wait_done();
    check_buffer(300);

    // constant input capture
    @(negedge adc_clk);
    adc_dat_i = 16'h831C;
    apb_write(8'(REG_CTRL), 32'd0, err);
    repeat (8) @(posedge adc_clk);
    apb_write(8'(REG_CTRL), 32'd2, err);
    wait_done();
    check_buffer(raw_to_sample('h831C));

    // buffer read right behind arm
    @(negedge adc_clk);
    adc_dat_i = 16'h7FFF;
    repeat (8) @(posedge adc_clk);
    apb_write(8'(REG_CTRL), 32'd2, err);
    apb_read(8'(int'(BUF_BASE) + 4), d, err, w);
    if (w == 0)
    begin
      $display("buffer read during capture completed without waiting");
      stop_on_error();
    end
    check_sample("buffer word 1", sample_t'(d[SAMPLE_W-1:0]),
                 sample_t'(raw_to_sample('h7FFF)));
    apb_write(BUF_BASE, 32'h0, err);  // buffer is read only
    check_word("pslverr", 32'(err), 32'd1);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/loop_pkg.sv
hw/adc_frontend.sv
hw/p_controller.sv
hw/dac_output.sv
hw/capture_ctrl.sv
hw/sample_buffer.sv
hw/apb_regs.sv
hw/loop_ctrl_top.sv
sim/tb_props.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLAGS     ?= --binary --timing --assert -Wno-fatal
BUILD     ?= obj_dir

SRCS := $(shell grep -v '^+' build.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): build.f $(SRCS)
	$(VERILATOR) $(FLAGS) -f build.f --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(BUILD)
